//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sim.f --top-module tb_rv_idu -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_rv_idu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

//--- hdl/rv_idu.sv
`include "rv_idu_params.svh"

module rv_idu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ifu_vld,
  input  logic [`RV_INST_W-1:0] ifu_inst,
  input  logic [`RV_XLEN-1:0]   ifu_pc,
  input  logic                  alu_vld,
  input  logic                  alu_retired,
  input  logic                  alu_freeze,
  input  logic                  alu_br_miss,
  input  logic                  alu_trap,
  output logic                  idu_vld,
  output logic                  idu_freeze,
  output rv_idu_pkg::op_e       idu_op,
  output logic [`RV_REG_W-1:0]  idu_rs1,
  output logic [`RV_REG_W-1:0]  idu_rs2,
  output logic [`RV_REG_W-1:0]  idu_rd,
  output logic [`RV_XLEN-1:0]   idu_imm,
  output logic [`RV_XLEN-1:0]   idu_pc
);

  rv_idu_dec_if dec_if ();

  assign dec_if.pc = ifu_pc;

  rv_inst_classify classify_i (
    .inst (ifu_inst),
    .dec  (dec_if.dec)
  );

  rv_imm_gen imm_gen_i (
    .inst (ifu_inst),
    .dec  (dec_if.dec)
  );

  rv_idu_stage stage_i (
    .clk         (clk),
    .rst         (rst),
    .ifu_vld     (ifu_vld),
    .alu_vld     (alu_vld),
    .alu_retired (alu_retired),
    .alu_freeze  (alu_freeze),
    .alu_br_miss (alu_br_miss),
    .alu_trap    (alu_trap),
    .dec         (dec_if.stage),
    .idu_vld     (idu_vld),
    .idu_freeze  (idu_freeze),
    .idu_op      (idu_op),
    .idu_rs1     (idu_rs1),
    .idu_rs2     (idu_rs2),
    .idu_rd      (idu_rd),
    .idu_imm     (idu_imm),
    .idu_pc      (idu_pc)
  );

endmodule

//--- hdl/rv_idu_dec_if.sv
`include "rv_idu_params.svh"

interface rv_idu_dec_if;
  import rv_idu_pkg::*;

  op_e                  op;
  logic [`RV_REG_W-1:0] rs1;
  logic [`RV_REG_W-1:0] rs2;
  logic [`RV_REG_W-1:0] rd;
  logic [`RV_XLEN-1:0]  imm;
  logic [`RV_XLEN-1:0]  pc;  // Fetch PC, passed straight through

  modport dec (output op, rs1, rs2, rd, imm, pc);

  modport stage (input op, rs1, rs2, rd, imm, pc);

endinterface

//--- hdl/rv_idu_params.svh
`ifndef RV_IDU_PARAMS_SVH
`define RV_IDU_PARAMS_SVH

// Instruction word width
`define RV_INST_W 32

// Data path and PC width
`define RV_XLEN 32

// Register file address width
`define RV_REG_W 5

`endif

//--- hdl/rv_idu_pkg.sv
package rv_idu_pkg;

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // Decoded operation handed to the ALU
  typedef enum logic [5:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_FENCE, OP_ECALL, OP_EBREAK,
    OP_ILLEGAL
  } op_e;

endpackage

//--- hdl/rv_idu_stage.sv
`include "rv_idu_params.svh"

module rv_idu_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ifu_vld,
  input  logic                 alu_vld,
  input  logic                 alu_retired,
  input  logic                 alu_freeze,
  input  logic                 alu_br_miss,
  input  logic                 alu_trap,
  rv_idu_dec_if.stage          dec,
  output logic                 idu_vld,
  output logic                 idu_freeze,
  output rv_idu_pkg::op_e      idu_op,
  output logic [`RV_REG_W-1:0] idu_rs1,
  output logic [`RV_REG_W-1:0] idu_rs2,
  output logic [`RV_REG_W-1:0] idu_rd,
  output logic [`RV_XLEN-1:0]  idu_imm,
  output logic [`RV_XLEN-1:0]  idu_pc
);
  import rv_idu_pkg::*;

  logic frozen;
  logic retire;
  logic flush;
  logic advance;
  logic is_mem;

  assign frozen  = alu_vld & alu_freeze;
  assign retire  = alu_vld & alu_retired;
  assign flush   = alu_vld & (alu_br_miss | alu_trap);
  assign advance = ~frozen | ~idu_vld | retire;
  assign is_mem  = dec.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};

  always_ff @(posedge clk) begin
    if (rst) begin
      idu_vld    <= 1'b0;
      idu_freeze <= 1'b0;
    end else begin
      if (advance) idu_vld <= ifu_vld & ~flush;  // Drop on branch miss or trap
      if (advance && is_mem) idu_freeze <= 1'b1;  // New load/store beats a retire
      else if (retire) idu_freeze <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      idu_op  <= dec.op;
      idu_rs1 <= dec.rs1;
      idu_rs2 <= dec.rs2;
      idu_rd  <= dec.rd;
      idu_imm <= dec.imm;
      idu_pc  <= dec.pc;
    end
  end

endmodule

//--- hdl/rv_imm_gen.sv
`include "rv_idu_params.svh"

module rv_imm_gen (
  input  logic [`RV_INST_W-1:0] inst,
  rv_idu_dec_if.dec             dec
);
  import rv_idu_pkg::*;

  opcode_e             opc;
  logic                shift_imm;
  logic                sgn;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opc       = opcode_e'(inst[6:0]);
  assign shift_imm = (inst[13:12] == 2'b01);  // funct3 001 or 101
  assign sgn       = inst[31];

  assign imm_i = {{(`RV_XLEN-12){sgn}}, inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){sgn}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){sgn}}, sgn, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){sgn}}, inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){sgn}}, sgn, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opc)
      OPC_LUI, OPC_AUIPC:                dec.imm = imm_u;
      OPC_JAL:                           dec.imm = imm_j;
      OPC_JALR, OPC_LOAD, OPC_MISC_MEM:  dec.imm = imm_i;
      OPC_BRANCH:                        dec.imm = imm_b;
      OPC_STORE:                         dec.imm = imm_s;
      OPC_OP_IMM: begin
        if (shift_imm) dec.imm = {{(`RV_XLEN-5){1'b0}}, inst[24:20]};  // shamt
        else dec.imm = imm_i;
      end
      default:                           dec.imm = '0;  // OP, SYSTEM, unknown
    endcase
  end

endmodule

//--- hdl/rv_inst_classify.sv
`include "rv_idu_params.svh"

module rv_inst_classify (
  input  logic [`RV_INST_W-1:0] inst,
  rv_idu_dec_if.dec             dec
);
  import rv_idu_pkg::*;

  opcode_e    opc;
  logic [2:0] funct3;
  logic [6:0] funct7;
  op_e        op_d;
  logic       use_rs1;
  logic       use_rs2;
  logic       use_rd;

  assign opc    = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    op_d    = OP_ILLEGAL;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    case (opc)
      OPC_LUI: begin
        op_d   = OP_LUI;
        use_rd = 1'b1;
      end
      OPC_AUIPC: begin
        op_d   = OP_AUIPC;
        use_rd = 1'b1;
      end
      OPC_JAL: begin
        op_d   = OP_JAL;
        use_rd = 1'b1;
      end
      OPC_JALR: begin
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        if (funct3 == 3'b000) op_d = OP_JALR;
      end
      OPC_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000:  op_d = OP_BEQ;
          3'b001:  op_d = OP_BNE;
          3'b100:  op_d = OP_BLT;
          3'b101:  op_d = OP_BGE;
          3'b110:  op_d = OP_BLTU;
          3'b111:  op_d = OP_BGEU;
          default: op_d = OP_ILLEGAL;
        endcase
      end
      OPC_LOAD: begin
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        case (funct3)
          3'b000:  op_d = OP_LB;
          3'b001:  op_d = OP_LH;
          3'b010:  op_d = OP_LW;
          3'b100:  op_d = OP_LBU;
          3'b101:  op_d = OP_LHU;
          default: op_d = OP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000:  op_d = OP_SB;
          3'b001:  op_d = OP_SH;
          3'b010:  op_d = OP_SW;
          default: op_d = OP_ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        case (funct3)
          3'b000: op_d = OP_ADDI;
          3'b010: op_d = OP_SLTI;
          3'b011: op_d = OP_SLTIU;
          3'b100: op_d = OP_XORI;
          3'b110: op_d = OP_ORI;
          3'b111: op_d = OP_ANDI;
          3'b001: if (funct7 == 7'b0000000) op_d = OP_SLLI;
          default: begin  // funct3 101, logical or arithmetic right shift
            if (funct7 == 7'b0000000) op_d = OP_SRLI;
            else if (funct7 == 7'b0100000) op_d = OP_SRAI;
          end
        endcase
      end
      OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: op_d = OP_ADD;
          10'b0100000_000: op_d = OP_SUB;
          10'b0000000_001: op_d = OP_SLL;
          10'b0000000_010: op_d = OP_SLT;
          10'b0000000_011: op_d = OP_SLTU;
          10'b0000000_100: op_d = OP_XOR;
          10'b0000000_101: op_d = OP_SRL;
          10'b0100000_101: op_d = OP_SRA;
          10'b0000000_110: op_d = OP_OR;
          10'b0000000_111: op_d = OP_AND;
          default:         op_d = OP_ILLEGAL;
        endcase
      end
      OPC_MISC_MEM: begin  // FENCE, ordering bits ride in the immediate
        op_d    = OP_FENCE;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000 && inst[31:20] == 12'h000) op_d = OP_ECALL;
        else if (funct3 == 3'b000 && inst[31:20] == 12'h001) op_d = OP_EBREAK;
      end
      default: op_d = OP_ILLEGAL;
    endcase
    if (op_d == OP_ILLEGAL) begin  // No register fields on a bad encoding
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      use_rd  = 1'b0;
    end
  end

  assign dec.op  = op_d;
  assign dec.rs1 = use_rs1 ? inst[19:15] : '0;
  assign dec.rs2 = use_rs2 ? inst[24:20] : '0;
  assign dec.rd  = use_rd  ? inst[11:7]  : '0;

endmodule

//--- sim.f
+incdir+hdl
hdl/rv_idu_pkg.sv
hdl/rv_idu_dec_if.sv
hdl/rv_inst_classify.sv
hdl/rv_imm_gen.sv
hdl/rv_idu_stage.sv
hdl/rv_idu.sv
verification/rv_idu_sva.sv
verification/tb_rv_idu.sv

//--- verification/rv_idu_sva.sv
`include "rv_idu_params.svh"

module rv_idu_sva (
  input logic                  clk,
  input logic                  rst,
  input logic [`RV_INST_W-1:0] ifu_inst,
  input logic                  alu_vld,
  input logic                  alu_retired,
  input logic                  alu_freeze,
  input logic                  idu_vld,
  input logic                  idu_freeze,
  input logic [5:0]            idu_op,
  input logic [`RV_XLEN-1:0]   idu_imm,
  input logic [`RV_XLEN-1:0]   idu_pc
);

  logic mem_in;

  assign mem_in = (ifu_inst[6:0] == 7'h03) || (ifu_inst[6:0] == 7'h23);

  a_reset: assert property (@(posedge clk) rst |=> !idu_vld && !idu_freeze)
    else $error("valid or freeze set after reset");

  a_hold: assert property (@(posedge clk) disable iff (rst)
    idu_vld && alu_vld && alu_freeze && !alu_retired |=>
      $stable(idu_vld) && $stable(idu_op) && $stable(idu_imm) && $stable(idu_pc))
    else $error("outputs changed during hold");

  a_unfreeze: assert property (@(posedge clk) disable iff (rst)
    alu_vld && alu_retired && !mem_in |=> !idu_freeze)
    else $error("freeze level stuck after retire");

endmodule

bind rv_idu rv_idu_sva sva_i (
  .clk         (clk),
  .rst         (rst),
  .ifu_inst    (ifu_inst),
  .alu_vld     (alu_vld),
  .alu_retired (alu_retired),
  .alu_freeze  (alu_freeze),
  .idu_vld     (idu_vld),
  .idu_freeze  (idu_freeze),
  .idu_op      (idu_op),
  .idu_imm     (idu_imm),
  .idu_pc      (idu_pc)
);

//--- verification/tb_rv_idu.sv
`include "rv_idu_params.svh"

module tb_rv_idu;
  import rv_idu_pkg::*;

  logic                  clk;
  logic                  rst;
  logic                  ifu_vld;
  logic [`RV_INST_W-1:0] ifu_inst;
  logic [`RV_XLEN-1:0]   ifu_pc;
  logic                  alu_vld;
  logic                  alu_retired;
  logic                  alu_freeze;
  logic                  alu_br_miss;
  logic                  alu_trap;
  logic                  idu_vld;
  logic                  idu_freeze;
  op_e                   idu_op;
  logic [`RV_REG_W-1:0]  idu_rs1;
  logic [`RV_REG_W-1:0]  idu_rs2;
  logic [`RV_REG_W-1:0]  idu_rd;
  logic [`RV_XLEN-1:0]   idu_imm;
  logic [`RV_XLEN-1:0]   idu_pc;
  int                    cycles;

  rv_idu rv_idu_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 2000) begin
      $display("Timeout: tests did not finish within 2000 cycles");
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // Expected decode straight from the ISA encoding rules
  task automatic ref_decode(input logic [31:0] w, output op_e op, output logic [4:0] rs1,
                            output logic [4:0] rs2, output logic [4:0] rd,
                            output logic [31:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       u1;
    logic       u2;
    logic       ud;
    f3 = w[14:12];
    f7 = w[31:25];
    op = OP_ILLEGAL;
    {u1, u2, ud} = 3'b000;
    imm = 32'h0;
    case (w[6:0])
      7'h37: begin
        op = OP_LUI;
        ud = 1;
        imm = {w[31:12], 12'h0};
      end
      7'h17: begin
        op = OP_AUIPC;
        ud = 1;
        imm = {w[31:12], 12'h0};
      end
      7'h6f: begin
        op = OP_JAL;
        ud = 1;
        imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'h67: begin
        if (f3 == 0) op = OP_JALR;
        {u1, ud} = 2'b11;
        imm = {{20{w[31]}}, w[31:20]};
      end
      7'h63: begin
        op_e br_ops[8] = '{OP_BEQ, OP_BNE, OP_ILLEGAL, OP_ILLEGAL,
                           OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        op = br_ops[f3];
        {u1, u2} = 2'b11;
        imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      7'h03: begin
        op_e ld_ops[8] = '{OP_LB, OP_LH, OP_LW, OP_ILLEGAL,
                           OP_LBU, OP_LHU, OP_ILLEGAL, OP_ILLEGAL};
        op = ld_ops[f3];
        {u1, ud} = 2'b11;
        imm = {{20{w[31]}}, w[31:20]};
      end
      7'h23: begin
        if (f3 == 0) op = OP_SB;
        else if (f3 == 1) op = OP_SH;
        else if (f3 == 2) op = OP_SW;
        {u1, u2} = 2'b11;
        imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      7'h13: begin
        op_e im_ops[8] = '{OP_ADDI, OP_ILLEGAL, OP_SLTI, OP_SLTIU,
                           OP_XORI, OP_ILLEGAL, OP_ORI, OP_ANDI};
        op = im_ops[f3];
        if (f3 == 1 && f7 == 7'h00) op = OP_SLLI;
        if (f3 == 5 && f7 == 7'h00) op = OP_SRLI;
        if (f3 == 5 && f7 == 7'h20) op = OP_SRAI;
        {u1, ud} = 2'b11;
        imm = (f3 == 1 || f3 == 5) ? {27'h0, w[24:20]} : {{20{w[31]}}, w[31:20]};
      end
      7'h33: begin
        op_e r_ops[8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
        if (f7 == 7'h00) op = r_ops[f3];
        else if (f7 == 7'h20 && f3 == 0) op = OP_SUB;
        else if (f7 == 7'h20 && f3 == 5) op = OP_SRA;
        {u1, u2, ud} = 3'b111;
      end
      7'h0f: begin
        op = OP_FENCE;
        {u1, ud} = 2'b11;
        imm = {{20{w[31]}}, w[31:20]};
      end
      7'h73: begin
        if (f3 == 0 && w[31:20] == 12'h000) op = OP_ECALL;
        if (f3 == 0 && w[31:20] == 12'h001) op = OP_EBREAK;
      end
      default: op = OP_ILLEGAL;
    endcase
    if (op inside {OP_ILLEGAL, OP_ECALL, OP_EBREAK}) {u1, u2, ud} = 3'b000;
    rs1 = u1 ? w[19:15] : 5'h0;
    rs2 = u2 ? w[24:20] : 5'h0;
    rd  = ud ? w[11:7] : 5'h0;
  endtask

  function automatic logic [31:0] build(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [6:0] f7, input logic fix_f7);
    logic [31:0] w;
    w = $urandom;
    w[6:0] = opc;
    w[14:12] = f3;
    if (fix_f7) w[31:25] = f7;
    return w;
  endfunction

  task automatic drive(input logic v, input logic [31:0] inst, input logic [31:0] pc,
                       input logic av, input logic ret, input logic frz,
                       input logic brm, input logic trp);
    @(posedge clk);
    ifu_vld     <= v;
    ifu_inst    <= inst;
    ifu_pc      <= pc;
    alu_vld     <= av;
    alu_retired <= ret;
    alu_freeze  <= frz;
    alu_br_miss <= brm;
    alu_trap    <= trp;
  endtask

  task automatic wait_capture();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_outputs(input logic [31:0] inst, input logic [31:0] pc);
    op_e         op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    ref_decode(inst, op, rs1, rs2, rd, imm);
    check_val("idu_op", 32'(idu_op), 32'(op));
    check_val("idu_rs1", 32'(idu_rs1), 32'(rs1));
    check_val("idu_rs2", 32'(idu_rs2), 32'(rs2));
    check_val("idu_rd", 32'(idu_rd), 32'(rd));
    check_val("idu_imm", idu_imm, imm);
    check_val("idu_pc", idu_pc, pc);
  endtask

  task automatic decode_one(input logic [31:0] inst, input logic v);
    logic [31:0] pc;
    pc = $urandom & 32'hffff_fffc;
    drive(v, inst, pc, 0, 0, 0, 0, 0);
    wait_capture();
    check_val("idu_vld", 32'(idu_vld), 32'(v));
    check_outputs(inst, pc);
  endtask

  task automatic test_decode();
    int f;
    decode_one(build(7'h37, 3'($urandom), 0, 0), 1);
    decode_one(build(7'h17, 3'($urandom), 0, 0), 1);
    decode_one(build(7'h6f, 3'($urandom), 0, 0), 1);
    decode_one(build(7'h67, 0, 0, 0), 1);
    for (f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) decode_one(build(7'h63, 3'(f), 0, 0), 1);
      if (f != 3 && f < 6) decode_one(build(7'h03, 3'(f), 0, 0), 1);
      if (f < 3) decode_one(build(7'h23, 3'(f), 0, 0), 1);
      if (f != 1 && f != 5) decode_one(build(7'h13, 3'(f), 0, 0), 1);
      decode_one(build(7'h33, 3'(f), 7'h00, 1), 1);
    end
    decode_one(build(7'h13, 1, 7'h00, 1), 1);
    decode_one(build(7'h13, 5, 7'h00, 1), 1);
    decode_one(build(7'h13, 5, 7'h20, 1), 1);
    decode_one(build(7'h33, 0, 7'h20, 1), 1);
    decode_one(build(7'h33, 5, 7'h20, 1), 1);
    decode_one(build(7'h0f, 0, 0, 0), 1);
    decode_one(32'h0000_0073, 1);
    decode_one(32'h0010_0073, 1);
  endtask

  task automatic illegal_one(input logic [31:0] inst, input logic v);
    decode_one(inst, v);
    check_val("idu_op", 32'(idu_op), 32'(OP_ILLEGAL));
  endtask

  task automatic test_illegal();
    illegal_one(build(7'h63, 2, 0, 0), 1);
    illegal_one(build(7'h03, 3, 0, 0), 0);
    illegal_one(build(7'h23, 4, 0, 0), 1);
    illegal_one(build(7'h33, 0, 7'h01, 1), 1);
    illegal_one(build(7'h13, 1, 7'h20, 1), 0);
    illegal_one(build(7'h73, 1, 0, 0), 1);  // CSRRW
    illegal_one(build(7'h7f, 0, 0, 0), 1);
    illegal_one(32'h0020_0073, 1);
  endtask

  task automatic test_flush();
    decode_one(build(7'h13, 0, 0, 0), 1);
    drive(1, build(7'h13, 0, 0, 0), 32'h100, 1, 0, 0, 1, 0);
    wait_capture();
    check_val("idu_vld", 32'(idu_vld), 0);
    decode_one(build(7'h33, 0, 7'h00, 1), 1);
    drive(1, build(7'h13, 0, 0, 0), 32'h104, 1, 0, 0, 0, 1);
    wait_capture();
    check_val("idu_vld", 32'(idu_vld), 0);
  endtask

  task automatic freeze_one(input logic [31:0] inst);
    drive(0, 32'h0000_0013, 32'h1fc, 1, 1, 0, 0, 0);  // Retire anything left over
    wait_capture();
    check_val("idu_freeze", 32'(idu_freeze), 0);
    drive(1, inst, 32'h200, 0, 0, 0, 0, 0);
    wait_capture();
    check_val("idu_freeze", 32'(idu_freeze), 1);
    drive(0, 32'h0000_0013, 32'h204, 0, 0, 0, 0, 0);  // NOP while waiting
    repeat (3) wait_capture();
    check_val("idu_freeze", 32'(idu_freeze), 1);
    drive(0, 32'h0000_0013, 32'h208, 1, 1, 0, 0, 0);
    wait_capture();
    check_val("idu_freeze", 32'(idu_freeze), 0);
  endtask

  task automatic test_freeze();
    freeze_one(build(7'h03, 2, 0, 0));
    freeze_one(build(7'h23, 0, 0, 0));
  endtask

  task automatic test_hold();
    logic [31:0] a;
    logic [31:0] b;
    a = build(7'h13, 0, 0, 0);
    b = build(7'h33, 0, 7'h20, 1);
    drive(1, a, 32'h300, 0, 0, 0, 0, 0);
    wait_capture();
    check_outputs(a, 32'h300);
    drive(1, b, 32'h304, 1, 0, 1, 0, 0);
    repeat (3) wait_capture();
    check_val("idu_vld", 32'(idu_vld), 1);
    check_outputs(a, 32'h300);
    drive(1, b, 32'h304, 1, 1, 1, 0, 0);
    wait_capture();
    check_outputs(b, 32'h304);
  endtask

  initial begin
    void'($urandom(80220));
    cycles      = 0;
    rst         = 1'b1;
    ifu_vld     = 1'b0;
    ifu_inst    = 32'h0000_0013;
    ifu_pc      = 32'h0;
    alu_vld     = 1'b0;
    alu_retired = 1'b0;
    alu_freeze  = 1'b0;
    alu_br_miss = 1'b0;
    alu_trap    = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_decode();
    test_illegal();
    test_flush();
    test_freeze();
    test_hold();
    $display("=== PASS ===");
    $finish;
  end

endmodule
